/* rtl/l1c_cfg.svh */
`ifndef L1C_CFG_SVH
`define L1C_CFG_SVH

// Core word and line geometry
`define L1C_WORD_BITS   32
`define L1C_LINE_WORDS  8

// Set count, ways fixed at two by the NMRU scheme
`define L1C_SETS        16
`define L1C_WAYS        2

// Derived widths of the address fields
`define L1C_LINE_BITS   (`L1C_WORD_BITS * `L1C_LINE_WORDS)
`define L1C_WOFF_BITS   $clog2(`L1C_LINE_WORDS)
`define L1C_BOFF_BITS   ($clog2(`L1C_WORD_BITS / 8) + `L1C_WOFF_BITS)
`define L1C_INDEX_BITS  $clog2(`L1C_SETS)
`define L1C_TAG_BITS    (`L1C_WORD_BITS - `L1C_INDEX_BITS - `L1C_BOFF_BITS)

`endif

/* rtl/l1c_pkg.sv */
`include "l1c_cfg.svh"
`default_nettype none

package l1c_pkg;

    // Core word, also used for byte addresses
    typedef logic [`L1C_WORD_BITS-1:0] word_t;

    // Whole cache line, word 0 in the low bits
    typedef logic [`L1C_LINE_BITS-1:0] line_t;

    // Address fields
    typedef logic [`L1C_TAG_BITS-1:0] tag_t;
    typedef logic [`L1C_INDEX_BITS-1:0] index_t;
    typedef logic [`L1C_WOFF_BITS-1:0] offset_t;

    // ******************************************************************
    // Tag store entry, one per way and set
    // ******************************************************************
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

endpackage

`default_nettype wire

/* rtl/l1c_array.sv */
`include "l1c_cfg.svh"
`default_nettype none

module l1c_array #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = `L1C_SETS
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            rd_en,
    input  l1c_pkg::index_t rd_index,
    output entry_t          rd_entry,
    input  logic            wr_en,
    input  l1c_pkg::index_t wr_index,
    input  entry_t          wr_entry,
    input  logic            clear
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (clear) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_index] <= wr_entry;
        end
    end

    // Registered read, a write to the same entry in this cycle is passed on
    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (clear) begin
                rd_entry <= '0;
            end else if (wr_en && (wr_index == rd_index)) begin
                rd_entry <= wr_entry;
            end else begin
                rd_entry <= mem[rd_index];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/l1c_datapath.sv */
`include "l1c_cfg.svh"
`default_nettype none

module l1c_datapath (
    input  logic           clk,
    input  logic           arst_n,
    input  l1c_pkg::word_t core_l1cache_addr,
    input  l1c_pkg::word_t core_l1cache_wdata,
    output l1c_pkg::word_t l1cache_core_rdata,
    output l1c_pkg::word_t l1cache_ddr_addr,
    input  l1c_pkg::line_t ddr_l1cache_rdata,
    output l1c_pkg::line_t l1cache_ddr_wdata,
    output logic           hit,
    output logic           victim_dirty,
    input  logic           lookup,
    input  logic           nmru_update,
    input  logic           line_write,
    input  logic           line_fill,
    input  logic           wb_select
);

    localparam int WAYS = `L1C_WAYS;

    l1c_pkg::tag_t       req_tag;
    l1c_pkg::index_t     req_index;
    l1c_pkg::offset_t    req_offset;
    l1c_pkg::tag_entry_t tag_rd [WAYS];
    l1c_pkg::line_t      line_rd [WAYS];
    l1c_pkg::tag_entry_t tag_wr;
    l1c_pkg::line_t      line_wr;
    l1c_pkg::line_t      merged;
    logic [WAYS-1:0]     way_hit;
    logic [WAYS-1:0]     way_wr;
    logic                hit_way;
    logic                victim_way;
    logic [`L1C_SETS-1:0] nmru;

    assign req_tag    = core_l1cache_addr[`L1C_WORD_BITS-1 -: `L1C_TAG_BITS];
    assign req_index  = core_l1cache_addr[`L1C_BOFF_BITS +: `L1C_INDEX_BITS];
    assign req_offset = core_l1cache_addr[`L1C_BOFF_BITS-1 -: `L1C_WOFF_BITS];

    // ******************************************************************
    // Tag and data storage, one pair of arrays per way
    // ******************************************************************
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        assign way_hit[w] = tag_rd[w].valid && (tag_rd[w].tag == req_tag);
        assign way_wr[w]  = (line_write && (hit_way == 1'(w)))
                          || (line_fill && (victim_way == 1'(w)));

        l1c_array #(.entry_t(l1c_pkg::tag_entry_t)) tag_array_i (
            .clk      (clk),
            .arst_n   (arst_n),
            .rd_en    (lookup),
            .rd_index (req_index),
            .rd_entry (tag_rd[w]),
            .wr_en    (way_wr[w]),
            .wr_index (req_index),
            .wr_entry (tag_wr),
            .clear    (1'b0)
        );

        l1c_array #(.entry_t(l1c_pkg::line_t)) data_array_i (
            .clk      (clk),
            .arst_n   (arst_n),
            .rd_en    (lookup),
            .rd_index (req_index),
            .rd_entry (line_rd[w]),
            .wr_en    (way_wr[w]),
            .wr_index (req_index),
            .wr_entry (line_wr),
            .clear    (1'b0)
        );
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // Empty way first, else the way the NMRU bit points at
    always_comb begin
        if (!tag_rd[0].valid) begin
            victim_way = 1'b0;
        end else if (!tag_rd[1].valid) begin
            victim_way = 1'b1;
        end else begin
            victim_way = nmru[req_index];
        end
    end

    assign victim_dirty = tag_rd[victim_way].valid && tag_rd[victim_way].dirty;

    // Core word into the hit line
    always_comb begin
        merged = line_rd[hit_way];
        merged[req_offset * `L1C_WORD_BITS +: `L1C_WORD_BITS] = core_l1cache_wdata;
    end

    // A fill leaves the line clean, a core write marks it dirty
    always_comb begin
        tag_wr.valid = 1'b1;
        tag_wr.dirty = !line_fill;
        tag_wr.tag   = req_tag;
        line_wr      = line_fill ? ddr_l1cache_rdata : merged;
    end

    assign l1cache_core_rdata = line_rd[hit_way][req_offset * `L1C_WORD_BITS +: `L1C_WORD_BITS];

    assign l1cache_ddr_addr  = {(wb_select ? tag_rd[victim_way].tag : req_tag),
                                req_index, {`L1C_BOFF_BITS{1'b0}}};
    assign l1cache_ddr_wdata = line_rd[victim_way];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            nmru <= '0;
        end else if (nmru_update) begin
            nmru[req_index] <= ~hit_way;
        end
    end

endmodule

`default_nettype wire

/* rtl/l1c_control.sv */
`default_nettype none

module l1c_control (
    input  logic clk,
    input  logic arst_n,
    input  logic core_l1cache_read,
    input  logic core_l1cache_write,
    output logic l1cache_core_resp,
    output logic l1cache_ddr_read,
    output logic l1cache_ddr_write,
    input  logic ddr_l1cache_resp,
    input  logic hit,
    input  logic victim_dirty,
    output logic lookup,
    output logic nmru_update,
    output logic line_write,
    output logic line_fill,
    output logic wb_select
);

    typedef enum logic [1:0] {
        st_idle,
        st_compare,
        st_writeback,
        st_fill
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // ******************************************************************
    // Next state and outputs
    // ******************************************************************
    always_comb begin
        state_next        = state;
        l1cache_core_resp = 1'b0;
        l1cache_ddr_read  = 1'b0;
        l1cache_ddr_write = 1'b0;
        lookup            = 1'b0;
        nmru_update       = 1'b0;
        line_write        = 1'b0;
        line_fill         = 1'b0;
        wb_select         = 1'b0;

        unique case (state)
            st_idle: begin
                if (core_l1cache_read || core_l1cache_write) begin
                    lookup     = 1'b1;
                    state_next = st_compare;
                end
            end
            st_compare: begin
                if (hit) begin
                    l1cache_core_resp = 1'b1;
                    nmru_update       = 1'b1;
                    line_write        = core_l1cache_write;
                    state_next        = st_idle;
                end else if (victim_dirty) begin
                    state_next = st_writeback;
                end else begin
                    state_next = st_fill;
                end
            end
            st_writeback: begin
                // Victim line out, address from its own tag
                l1cache_ddr_write = 1'b1;
                wb_select         = 1'b1;
                if (ddr_l1cache_resp) begin
                    state_next = st_fill;
                end
            end
            st_fill: begin
                l1cache_ddr_read = 1'b1;
                if (ddr_l1cache_resp) begin
                    // Write the line and read it back for the re-lookup
                    line_fill  = 1'b1;
                    lookup     = 1'b1;
                    state_next = st_compare;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/l1cache.sv */
`default_nettype none

module l1cache (
    input  logic           clk,
    input  logic           arst_n,

    input  l1c_pkg::word_t core_l1cache_addr,
    input  logic           core_l1cache_read,
    input  logic           core_l1cache_write,
    output l1c_pkg::word_t l1cache_core_rdata,
    input  l1c_pkg::word_t core_l1cache_wdata,
    output logic           l1cache_core_resp,

    output l1c_pkg::word_t l1cache_ddr_addr,
    output logic           l1cache_ddr_read,
    output logic           l1cache_ddr_write,
    input  l1c_pkg::line_t ddr_l1cache_rdata,
    output l1c_pkg::line_t l1cache_ddr_wdata,
    input  logic           ddr_l1cache_resp
);

    logic hit;
    logic victim_dirty;
    logic lookup;
    logic nmru_update;
    logic line_write;
    logic line_fill;
    logic wb_select;

    l1c_datapath datapath_i (
        .clk                (clk),
        .arst_n             (arst_n),
        .core_l1cache_addr  (core_l1cache_addr),
        .core_l1cache_wdata (core_l1cache_wdata),
        .l1cache_core_rdata (l1cache_core_rdata),
        .l1cache_ddr_addr   (l1cache_ddr_addr),
        .ddr_l1cache_rdata  (ddr_l1cache_rdata),
        .l1cache_ddr_wdata  (l1cache_ddr_wdata),
        .hit                (hit),
        .victim_dirty       (victim_dirty),
        .lookup             (lookup),
        .nmru_update        (nmru_update),
        .line_write         (line_write),
        .line_fill          (line_fill),
        .wb_select          (wb_select)
    );

    l1c_control control_i (
        .clk                (clk),
        .arst_n             (arst_n),
        .core_l1cache_read  (core_l1cache_read),
        .core_l1cache_write (core_l1cache_write),
        .l1cache_core_resp  (l1cache_core_resp),
        .l1cache_ddr_read   (l1cache_ddr_read),
        .l1cache_ddr_write  (l1cache_ddr_write),
        .ddr_l1cache_resp   (ddr_l1cache_resp),
        .hit                (hit),
        .victim_dirty       (victim_dirty),
        .lookup             (lookup),
        .nmru_update        (nmru_update),
        .line_write         (line_write),
        .line_fill          (line_fill),
        .wb_select          (wb_select)
    );

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset released just after the 16th rising edge
    initial begin
        arst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* bench/ddr_model.sv */
`include "l1c_cfg.svh"
`default_nettype none

module ddr_model #(
    parameter int             LATENCY  = 3,
    parameter l1c_pkg::word_t FILL_KEY = 32'h0
) (
    input  logic           clk,
    input  logic           arst_n,
    input  l1c_pkg::word_t addr,
    input  logic           read,
    input  logic           write,
    input  l1c_pkg::line_t wdata,
    output l1c_pkg::line_t rdata,
    output logic           resp,
    output int             read_count,
    output int             write_count,
    output l1c_pkg::word_t last_rd_addr,
    output l1c_pkg::word_t last_wr_addr,
    output l1c_pkg::line_t last_wr_line
);
    timeunit 1ns;
    timeprecision 100ps;

    l1c_pkg::line_t mem [l1c_pkg::word_t];
    l1c_pkg::word_t op_addr;
    l1c_pkg::line_t op_line;
    logic           op_write;
    int             wait_cnt;

    // Lines never written hold each word's own address mixed with a key
    function automatic l1c_pkg::line_t fetch(input l1c_pkg::word_t a);
        l1c_pkg::line_t line;
        if (mem.exists(a)) begin
            return mem[a];
        end
        for (int i = 0; i < `L1C_LINE_WORDS; i++) begin
            line[i*`L1C_WORD_BITS +: `L1C_WORD_BITS] = l1c_pkg::word_t'(a + 4*i) ^ FILL_KEY;
        end
        return line;
    endfunction

    initial begin
        resp         = 1'b0;
        rdata        = '0;
        read_count   = 0;
        write_count  = 0;
        last_rd_addr = '0;
        last_wr_addr = '0;
        last_wr_line = '0;
        wait_cnt     = 0;
        forever begin
            @(posedge clk);
            if (resp || !arst_n || !(read || write)) begin
                wait_cnt = 0;
                #1 resp = 1'b0;
            end else if (wait_cnt < LATENCY) begin
                wait_cnt++;
            end else begin
                wait_cnt = 0;
                op_addr  = addr;
                op_line  = wdata;
                op_write = write;
                #1;
                if (op_write) begin
                    mem[op_addr] = op_line;
                    last_wr_addr = op_addr;
                    last_wr_line = op_line;
                    write_count++;
                end else begin
                    rdata        = fetch(op_addr);
                    last_rd_addr = op_addr;
                    read_count++;
                end
                resp = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/l1cache_sva.sv */
`default_nettype none

module l1cache_sva (
    input logic           clk,
    input logic           arst_n,
    input l1c_pkg::word_t core_l1cache_addr,
    input logic           core_l1cache_read,
    input logic           core_l1cache_write,
    input l1c_pkg::word_t core_l1cache_wdata,
    input logic           l1cache_core_resp,
    input l1c_pkg::word_t l1cache_ddr_addr,
    input logic           l1cache_ddr_read,
    input logic           l1cache_ddr_write,
    input l1c_pkg::line_t l1cache_ddr_wdata,
    input logic           ddr_l1cache_resp
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // **********************************************************************
    // Requests held steady until the response edge
    // **********************************************************************
    core_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (core_l1cache_read || core_l1cache_write) && !l1cache_core_resp
        |=> $stable(core_l1cache_addr) && $stable(core_l1cache_wdata)
            && $stable(core_l1cache_read) && $stable(core_l1cache_write))
        else begin
            $error("core request changed before its response");
            fail_count++;
        end

    ddr_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (l1cache_ddr_read || l1cache_ddr_write) && !ddr_l1cache_resp
        |=> $stable(l1cache_ddr_addr) && $stable(l1cache_ddr_wdata)
            && $stable(l1cache_ddr_read) && $stable(l1cache_ddr_write))
        else begin
            $error("DDR request changed before its response");
            fail_count++;
        end

    // Core read and write are exclusive
    core_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        !(core_l1cache_read && core_l1cache_write))
        else begin
            $error("core read and write both high");
            fail_count++;
        end

endmodule

bind l1cache l1cache_sva sva_i (.*);

`default_nettype wire

/* bench/tb_l1cache.sv */
`include "l1c_cfg.svh"
`default_nettype none

module tb_l1cache;
    timeunit 1ns;
    timeprecision 100ps;

    localparam l1c_pkg::word_t FILL_KEY = 32'h5ca1_ab1e;
    localparam int DDR_LATENCY   = 3;
    localparam int RESP_TIMEOUT  = 200;
    localparam int RESET_TIMEOUT = 100;
    localparam int STEPS         = 17;

    typedef struct packed {
        logic           write;
        l1c_pkg::word_t addr;
        logic [3:0]     ddr_rd;
        logic [3:0]     ddr_wr;
        l1c_pkg::word_t wb_line;
    } step_t;

    // **********************************************************************
    // Set 5 holds X 0x40a0, Y 0x42a0, Z 0x44a0
    // Set 3 holds A 0x10000060, B 0x20000060, C 0x30000060
    // **********************************************************************
    step_t steps [STEPS] = '{
        '{1'b0, 32'h0000_40a4, 4'd1, 4'd0, 32'h0},            // read miss X
        '{1'b0, 32'h0000_40a8, 4'd0, 4'd0, 32'h0},
        '{1'b1, 32'h0000_40a8, 4'd0, 4'd0, 32'h0},            // write hit, X now dirty
        '{1'b0, 32'h0000_40a8, 4'd0, 4'd0, 32'h0},
        '{1'b0, 32'h0000_42b0, 4'd1, 4'd0, 32'h0},            // Y into the empty way
        '{1'b0, 32'h0000_44a0, 4'd1, 4'd1, 32'h0000_40a0},    // Z evicts dirty X
        '{1'b0, 32'h0000_40a8, 4'd1, 4'd0, 32'h0},            // X back from DDR
        '{1'b0, 32'h1000_0060, 4'd1, 4'd0, 32'h0},
        '{1'b0, 32'h2000_0064, 4'd1, 4'd0, 32'h0},
        '{1'b0, 32'h1000_0068, 4'd0, 4'd0, 32'h0},            // A most recent
        '{1'b0, 32'h3000_006c, 4'd1, 4'd0, 32'h0},            // C replaces B
        '{1'b0, 32'h1000_006c, 4'd0, 4'd0, 32'h0},
        '{1'b0, 32'h2000_0064, 4'd1, 4'd0, 32'h0},
        '{1'b1, 32'h3000_007c, 4'd1, 4'd0, 32'h0},            // write miss allocates C
        '{1'b0, 32'h3000_007c, 4'd0, 4'd0, 32'h0},
        '{1'b0, 32'h2000_0060, 4'd0, 4'd0, 32'h0},
        '{1'b0, 32'h1000_0060, 4'd1, 4'd1, 32'h3000_0060}     // A evicts dirty C
    };

    logic           clk;
    logic           arst_n;
    l1c_pkg::word_t core_l1cache_addr;
    logic           core_l1cache_read;
    logic           core_l1cache_write;
    l1c_pkg::word_t core_l1cache_wdata;
    l1c_pkg::word_t l1cache_core_rdata;
    logic           l1cache_core_resp;
    l1c_pkg::word_t l1cache_ddr_addr;
    logic           l1cache_ddr_read;
    logic           l1cache_ddr_write;
    l1c_pkg::line_t ddr_l1cache_rdata;
    l1c_pkg::line_t l1cache_ddr_wdata;
    logic           ddr_l1cache_resp;
    int             ddr_read_count;
    int             ddr_write_count;
    l1c_pkg::word_t ddr_last_rd_addr;
    l1c_pkg::word_t ddr_last_wr_addr;
    l1c_pkg::line_t ddr_last_wr_line;

    l1c_pkg::word_t shadow [l1c_pkg::word_t];
    logic [31:0]    rng;
    l1c_pkg::word_t data;
    step_t          step;
    int             errors;
    int             bad_steps;
    int             step_errors;
    int             cycles;
    int             rd_before;
    int             wr_before;
    bit             ok;
    bit             timed_out;

    tb_clock clock_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    ddr_model #(.LATENCY(DDR_LATENCY), .FILL_KEY(FILL_KEY)) ddr_model_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .addr         (l1cache_ddr_addr),
        .read         (l1cache_ddr_read),
        .write        (l1cache_ddr_write),
        .wdata        (l1cache_ddr_wdata),
        .rdata        (ddr_l1cache_rdata),
        .resp         (ddr_l1cache_resp),
        .read_count   (ddr_read_count),
        .write_count  (ddr_write_count),
        .last_rd_addr (ddr_last_rd_addr),
        .last_wr_addr (ddr_last_wr_addr),
        .last_wr_line (ddr_last_wr_line)
    );

    l1cache l1cache_i (
        .clk                (clk),
        .arst_n             (arst_n),
        .core_l1cache_addr  (core_l1cache_addr),
        .core_l1cache_read  (core_l1cache_read),
        .core_l1cache_write (core_l1cache_write),
        .l1cache_core_rdata (l1cache_core_rdata),
        .core_l1cache_wdata (core_l1cache_wdata),
        .l1cache_core_resp  (l1cache_core_resp),
        .l1cache_ddr_addr   (l1cache_ddr_addr),
        .l1cache_ddr_read   (l1cache_ddr_read),
        .l1cache_ddr_write  (l1cache_ddr_write),
        .ddr_l1cache_rdata  (ddr_l1cache_rdata),
        .l1cache_ddr_wdata  (l1cache_ddr_wdata),
        .ddr_l1cache_resp   (ddr_l1cache_resp)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Written words from the shadow, all others from the DDR fill pattern
    function automatic l1c_pkg::word_t expected_word(input l1c_pkg::word_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ FILL_KEY;
    endfunction

    // Sampled mid-cycle, a hit shows up one cycle after the request
    task automatic wait_core_resp(output bit seen, output int n);
        seen = 1'b0;
        n    = 0;
        while (!seen && n < RESP_TIMEOUT) begin
            @(negedge clk);
            if (l1cache_core_resp) begin
                seen = 1'b1;
            end else begin
                n++;
            end
        end
    endtask

    task automatic check_writeback(input int s);
        l1c_pkg::word_t a;
        l1c_pkg::word_t w;
        a = step.wb_line;
        assert (ddr_last_wr_addr == a) else begin
            $display("Error at %0t ns: step %0d DDR write at %h, expected line %h",
                     $time, s, ddr_last_wr_addr, a);
            errors++;
        end
        for (int i = 0; i < `L1C_LINE_WORDS; i++) begin
            w = ddr_last_wr_line[i*`L1C_WORD_BITS +: `L1C_WORD_BITS];
            assert (w == expected_word(l1c_pkg::word_t'(a + 4*i))) else begin
                $display("Error at %0t ns: writeback of line %h word %0d is %h, expected %h",
                         $time, a, i, w, expected_word(l1c_pkg::word_t'(a + 4*i)));
                errors++;
            end
        end
    endtask

    task automatic check_step(input int s);
        assert (ddr_read_count - rd_before == int'(step.ddr_rd)) else begin
            $display("Error at %0t ns: step %0d made %0d DDR reads, expected %0d",
                     $time, s, ddr_read_count - rd_before, step.ddr_rd);
            errors++;
        end
        assert (ddr_write_count - wr_before == int'(step.ddr_wr)) else begin
            $display("Error at %0t ns: step %0d made %0d DDR writes, expected %0d",
                     $time, s, ddr_write_count - wr_before, step.ddr_wr);
            errors++;
        end
        if (step.ddr_rd != 0) begin
            assert (ddr_last_rd_addr == (step.addr & 32'hffff_ffe0)) else begin
                $display("Error at %0t ns: step %0d DDR read at %h, expected line %h",
                         $time, s, ddr_last_rd_addr, step.addr & 32'hffff_ffe0);
                errors++;
            end
        end
        if (step.ddr_wr != 0) begin
            check_writeback(s);
        end
        if (step.ddr_rd == 0 && step.ddr_wr == 0) begin
            assert (cycles == 1) else begin
                $display("Error at %0t ns: step %0d hit took %0d cycles, expected 1",
                         $time, s, cycles);
                errors++;
            end
        end
        if (!step.write) begin
            assert (data == expected_word(step.addr)) else begin
                $display("Error at %0t ns: step %0d read %h from %h, expected %h",
                         $time, s, data, step.addr, expected_word(step.addr));
                errors++;
            end
        end
    endtask

    initial begin
        core_l1cache_addr  = '0;
        core_l1cache_read  = 1'b0;
        core_l1cache_write = 1'b0;
        core_l1cache_wdata = '0;
        rng       = 32'hed7f8295;
        errors    = 0;
        bad_steps = 0;
        timed_out = 1'b0;
        cycles    = 0;
        while (!arst_n && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!arst_n) begin
            $display("Timeout: reset was never released");
            timed_out = 1'b1;
        end

        for (int s = 0; s < STEPS && !timed_out; s++) begin
            step        = steps[s];
            rd_before   = ddr_read_count;
            wr_before   = ddr_write_count;
            step_errors = errors;
            @(posedge clk);
            #1;
            core_l1cache_addr = step.addr;
            if (step.write) begin
                rng                = xorshift(rng);
                core_l1cache_wdata = rng;
                core_l1cache_write = 1'b1;
            end else begin
                core_l1cache_wdata = '0;
                core_l1cache_read  = 1'b1;
            end
            wait_core_resp(ok, cycles);
            if (!ok) begin
                $display("Timeout: no core response for step %0d after %0d cycles", s, cycles);
                timed_out = 1'b1;
            end else begin
                data = step.write ? core_l1cache_wdata : l1cache_core_rdata;
                check_step(s);
                if (step.write) begin
                    shadow[step.addr] = core_l1cache_wdata;
                end
                @(posedge clk);
                #1;
                core_l1cache_read  = 1'b0;
                core_l1cache_write = 1'b0;
                if (errors != step_errors) begin
                    bad_steps++;
                end
                $display("Step %0d %s addr %h data %h ddr rd %0d wr %0d cycles %0d %s",
                         s, step.write ? "write" : "read", step.addr, data,
                         ddr_read_count - rd_before, ddr_write_count - wr_before, cycles,
                         (errors == step_errors) ? "ok" : "mismatch");
            end
        end

        $display("Steps %0d, bad steps %0d, errors %0d, assertion failures %0d, timeout %0d",
                 STEPS, bad_steps, errors, l1cache_i.sva_i.fail_count, timed_out);
        if (errors == 0 && l1cache_i.sva_i.fail_count == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+rtl
rtl/l1c_pkg.sv
rtl/l1c_array.sv
rtl/l1c_datapath.sv
rtl/l1c_control.sv
rtl/l1cache.sv
bench/tb_clock.sv
bench/ddr_model.sv
bench/l1cache_sva.sv
bench/tb_l1cache.sv
